/* common/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // ------------------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------------------

    localparam int bus_addr_width = 16;  // Word address
    localparam int bus_data_width = 64;

    // Widest fabric supported
    localparam int max_ports = 8;

    // ------------------------------------------------------------------------
    // Word types
    // ------------------------------------------------------------------------

    typedef logic [bus_addr_width-1:0] addr_t;
    typedef logic [bus_data_width-1:0] data_t;

    // Requester number, wide enough for max_ports
    typedef logic [2:0] port_idx_t;

endpackage

`default_nettype wire

/* common/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    // Request side, valid while start is high
    logic            start;
    logic            we;
    bus_pkg::addr_t  addr;
    bus_pkg::data_t  wdata;

    // Response side
    logic            busy;   // From the cycle after start through done
    logic            done;   // One cycle, latency cycles after start
    bus_pkg::data_t  rdata;  // Valid with done

    modport master (
        output start, we, addr, wdata,
        input  busy, done, rdata
    );

    modport slave (
        input  start, we, addr, wdata,
        output busy, done, rdata
    );

endinterface

`default_nettype wire

/* fabric/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
    parameter int num_ports = 7
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_ports-1:0] req,
    input  logic                 busy,
    output logic [num_ports-1:0] grant
);

    // ------------------------------------------------------------------------
    // Winner selection
    // ------------------------------------------------------------------------

    logic [num_ports-1:0] next_grant;  // One-hot, lowest index wins
    logic                 found;
    logic                 win;

    always_comb begin
        next_grant = '0;
        found      = 1'b0;
        for (int i = 0; i < num_ports; i++) begin
            if (!found && req[i]) begin
                next_grant[i] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    // Only an idle bus with a pending request moves the grant
    assign win = !busy && found;

    // ------------------------------------------------------------------------
    // Grant register
    // ------------------------------------------------------------------------

    // Holds its last owner until another winner appears
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
        end else if (win) begin
            grant <= next_grant;
        end
    end

endmodule

`default_nettype wire

/* fabric/bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_port (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic grant,
    input  logic busy,
    input  logic done,
    output logic start,
    output logic ack
);

    // Set while the transaction on the bus belongs to this requester
    logic active;

    // ------------------------------------------------------------------------
    // Issue and response
    // ------------------------------------------------------------------------

    // Single cycle, the set of active ends it
    assign start = grant && req && !busy && !active;

    // Grant may have moved on, active still routes the response here
    assign ack = active && done;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end else if (ack) begin
            active <= 1'b0;  // Transaction complete
        end
    end

endmodule

`default_nettype wire

/* fabric/bus_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_fabric #(
    parameter int num_ports = 7
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_ports-1:0] req,
    input  logic [num_ports-1:0] we,
    input  bus_pkg::addr_t       addr [num_ports],
    input  bus_pkg::data_t       wdata [num_ports],
    output logic [num_ports-1:0] ack,
    output logic [num_ports-1:0] grant,
    mem_bus_if.master            bus
);

    logic [num_ports-1:0] port_start;

    bus_arbiter #(
        .num_ports (num_ports)
    ) u_arbiter (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .busy  (bus.busy),
        .grant (grant)
    );

    // ------------------------------------------------------------------------
    // One adapter per requester
    // ------------------------------------------------------------------------

    for (genvar g = 0; g < num_ports; g++) begin : g_port
        bus_port u_port (
            .clk   (clk),
            .rst   (rst),
            .req   (req[g]),
            .grant (grant[g]),
            .busy  (bus.busy),
            .done  (bus.done),
            .start (port_start[g]),
            .ack   (ack[g])
        );
    end

    // At most one port starts, it is always the granted one
    assign bus.start = |port_start;

    // ------------------------------------------------------------------------
    // Request multiplexer
    // ------------------------------------------------------------------------

    always_comb begin
        bus.we    = 1'b0;
        bus.addr  = '0;
        bus.wdata = '0;
        for (int i = 0; i < num_ports; i++) begin
            bus.we    = bus.we | (grant[i] & we[i]);
            bus.addr  = bus.addr | (addr[i] & {bus_pkg::bus_addr_width{grant[i]}});
            bus.wdata = bus.wdata | (wdata[i] & {bus_pkg::bus_data_width{grant[i]}});
        end
    end

endmodule

`default_nettype wire

/* logic/bus_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_memory #(
    parameter int latency   = 3,
    parameter int mem_words = 256
) (
    input  logic     clk,
    input  logic     rst,
    mem_bus_if.slave bus
);

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = $clog2(latency + 1);

    bus_pkg::data_t mem [mem_words];

    // Latched request
    logic             we_q;
    logic [idx_w-1:0] idx_q;    // Address modulo mem_words
    bus_pkg::data_t   wdata_q;

    logic [cnt_w-1:0] cnt;      // Busy cycles so far
    logic             busy_q;
    logic             done_q;
    logic             accept;

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    assign accept = bus.start && !busy_q;

    // ------------------------------------------------------------------------
    // Latency counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt    <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt    <= cnt_w'(1);
            done_q <= (latency == 1);
        end else if (done_q) begin
            busy_q <= 1'b0;     // Bus free in the next cycle
            done_q <= 1'b0;
            cnt    <= '0;
        end else if (busy_q) begin
            cnt    <= cnt + 1'b1;
            done_q <= (cnt + 1'b1 == cnt_w'(latency));
        end
    end

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            we_q    <= bus.we;
            idx_q   <= bus.addr[idx_w-1:0];
            wdata_q <= bus.wdata;
        end
        if (done_q && we_q) begin
            mem[idx_q] <= wdata_q;  // Write lands at the end of the done cycle
        end
    end

    assign bus.busy  = busy_q;
    assign bus.done  = done_q;
    assign bus.rdata = (done_q && !we_q) ? mem[idx_q] : '0;  // Writes return zero

endmodule

`default_nettype wire

/* logic/bus_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_subsystem #(
    parameter int num_ports = 7,
    parameter int latency   = 3,
    parameter int mem_words = 256
) (
    input  logic                 clk,
    input  logic                 rst,

    // Requester side, one entry per port
    input  logic [num_ports-1:0] req,
    input  logic [num_ports-1:0] we,
    input  bus_pkg::addr_t       addr [num_ports],
    input  bus_pkg::data_t       wdata [num_ports],
    output logic [num_ports-1:0] ack,

    // Shared read data, valid with any ack
    output bus_pkg::data_t       rdata,
    output logic [num_ports-1:0] grant
);

    // ------------------------------------------------------------------------
    // Shared memory bus
    // ------------------------------------------------------------------------

    mem_bus_if bus_if ();

    bus_fabric #(
        .num_ports (num_ports)
    ) u_fabric (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .grant (grant),
        .bus   (bus_if.master)
    );

    bus_memory #(
        .latency   (latency),
        .mem_words (mem_words)
    ) u_memory (
        .clk (clk),
        .rst (rst),
        .bus (bus_if.slave)
    );

    assign rdata = bus_if.rdata;

endmodule

`default_nettype wire

/* test/tb_bus_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bus_subsystem;

    localparam int num_ports    = 7;
    localparam int latency      = 3;
    localparam int mem_words    = 256;
    localparam int idx_w        = $clog2(mem_words);
    localparam int job_w        = 1 + bus_pkg::bus_addr_width + bus_pkg::bus_data_width;
    localparam int req_timeout  = 3000;  // Cycles one request may wait for its ack
    localparam int idle_timeout = 5000;
    localparam int random_jobs  = 84;

    logic                 clk;
    logic                 rst;
    logic [num_ports-1:0] req;
    logic [num_ports-1:0] we;
    bus_pkg::addr_t       addr [num_ports];
    bus_pkg::data_t       wdata [num_ports];
    logic [num_ports-1:0] ack;
    bus_pkg::data_t       rdata;
    logic [num_ports-1:0] grant;

    logic [job_w-1:0]     jobs [num_ports][$];  // {we, addr, wdata} waiting per port
    logic [num_ports-1:0] pending;              // Issued and not yet acked
    int                   age [num_ports];
    bus_pkg::port_idx_t   expect_order [$];
    bus_pkg::data_t       model_mem [mem_words];
    bus_pkg::data_t       last_rdata;
    logic [31:0]          lcg_state;

    bus_subsystem #(
        .num_ports (num_ports),
        .latency   (latency),
        .mem_words (mem_words)
    ) DUT (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .grant (grant)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input bus_pkg::data_t got,
                              input bus_pkg::data_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_index(input string name, input bus_pkg::port_idx_t got,
                               input bus_pkg::port_idx_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Model read data for a word address that wraps at mem_words
    function automatic bus_pkg::data_t ref_read(input bus_pkg::addr_t a);
        return model_mem[a[idx_w-1:0]];
    endfunction

    function automatic bus_pkg::port_idx_t index_of(input logic [num_ports-1:0] v);
        bus_pkg::port_idx_t idx;
        idx = '0;
        for (int i = 0; i < num_ports; i++) begin
            if (v[i]) idx = bus_pkg::port_idx_t'(i);
        end
        return idx;
    endfunction

    task automatic queue_job(input int p, input logic w, input bus_pkg::addr_t a,
                             input bus_pkg::data_t d);
        jobs[p].push_back({w, a, d});
    endtask

    // Idle means nothing queued and every req low again
    task automatic wait_idle(input string what);
        int   cycles;
        logic open;
        cycles = 0;
        open   = 1'b1;
        while (open) begin
            @(posedge clk);
            cycles++;
            open = (req != '0);
            for (int p = 0; p < num_ports; p++) begin
                if (jobs[p].size() != 0) open = 1'b1;
            end
            if (open && cycles > idle_timeout) begin
                $display("timeout: %s still has open requests after %0d cycles", what, cycles);
                abort_run();
            end
        end
    endtask

    task automatic access(input int p, input logic w, input bus_pkg::addr_t a,
                          input bus_pkg::data_t d);
        queue_job(p, w, a, d);
        wait_idle("single access");
    endtask

    // ------------------------------------------------------------------------
    // Requester side with one level request per port
    // ------------------------------------------------------------------------

    initial begin : driver
        logic [job_w-1:0] job;
        req     = '0;
        we      = '0;
        pending = '0;
        for (int p = 0; p < num_ports; p++) begin
            addr[p]  = '0;
            wdata[p] = '0;
            age[p]   = 0;
        end
        forever begin
            @(negedge clk);
            for (int p = 0; p < num_ports; p++) begin
                if (req[p] && !pending[p]) begin
                    req[p] = 1'b0;  // Cycle after ack
                end else if (req[p]) begin
                    age[p]++;
                    if (age[p] > req_timeout) begin
                        $display("timeout: request from port %0d was never acknowledged", p);
                        abort_run();
                    end
                end else if (!rst && jobs[p].size() != 0) begin
                    job = jobs[p].pop_front();
                    {we[p], addr[p], wdata[p]} = job;
                    req[p]     = 1'b1;
                    pending[p] = 1'b1;
                    age[p]     = 0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Monitor that compares every ack against the model
    // ------------------------------------------------------------------------

    initial begin : monitor
        bus_pkg::port_idx_t idx;
        forever begin
            @(posedge clk);
            if (!rst) begin
                check_bit("grant_onehot0", $onehot0(grant), 1'b1);
                check_bit("ack_onehot0", $onehot0(ack), 1'b1);
                if (ack != '0) begin
                    idx = index_of(ack);
                    check_bit("req_at_ack", req[idx], 1'b1);
                    if (expect_order.size() != 0) begin
                        check_index("ack_port", idx, expect_order.pop_front());
                    end
                    if (we[idx]) begin
                        check_data("rdata", rdata, '0);  // Writes return zero
                        model_mem[addr[idx][idx_w-1:0]] = wdata[idx];
                    end else begin
                        check_data("rdata", rdata, ref_read(addr[idx]));
                    end
                    last_rdata   = rdata;
                    pending[idx] = 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin : main
        bus_pkg::port_idx_t p;
        logic [31:0]        r;
        logic [31:0]        hi;
        logic               w;
        bus_pkg::addr_t     a;
        int                 cycles;
        rst         = 1'b1;
        lcg_state   = 32'h7ce921e9;
        last_rdata  = '0;
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = '0;
        end

        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            check_bit("grant_in_reset", |grant, 1'b0);
            check_bit("ack_in_reset", |ack, 1'b0);
        end
        rst = 1'b0;
        repeat (2) @(negedge clk);
        check_bit("grant_after_reset", |grant, 1'b0);
        check_bit("ack_after_reset", |ack, 1'b0);

        // Single port writes and then reads back
        access(2, 1'b1, 16'd3, 64'h0123_4567_89ab_cdef);
        access(2, 1'b1, 16'd7, 64'hfeed_face_cafe_beef);
        access(2, 1'b1, 16'd12, 64'h1111_2222_3333_4444);
        access(2, 1'b1, 16'd7, 64'h5555_6666_7777_8888);  // Overwrite
        access(2, 1'b0, 16'd3, '0);
        check_data("rdata_addr3", last_rdata, 64'h0123_4567_89ab_cdef);
        access(2, 1'b0, 16'd7, '0);
        check_data("rdata_addr7", last_rdata, 64'h5555_6666_7777_8888);
        access(2, 1'b0, 16'd12, '0);
        check_data("rdata_addr12", last_rdata, 64'h1111_2222_3333_4444);
        access(2, 1'b0, 16'd5, '0);
        check_data("rdata_addr5", last_rdata, '0);

        // Port 6 takes the bus while ports 0 to 5 queue up behind it
        expect_order.push_back(bus_pkg::port_idx_t'(6));
        queue_job(6, 1'b0, 16'd3, '0);
        cycles = 0;
        while (!grant[6]) begin
            @(negedge clk);
            cycles++;
            if (cycles > idle_timeout) begin
                $display("timeout: port 6 never received the grant");
                abort_run();
            end
        end
        @(negedge clk);  // Bus is busy from here
        for (int i = 0; i < 6; i++) begin
            expect_order.push_back(bus_pkg::port_idx_t'(i));
            queue_job(i, 1'b1, bus_pkg::addr_t'(8 + i), {32'(i), 32'hc0de_0000});
        end
        wait_idle("ordered requests");

        // Random traffic over 16 words
        for (int n = 0; n < random_jobs; n++) begin
            r  = lcg_next();
            p  = bus_pkg::port_idx_t'((r >> 16) % num_ports);
            w  = r[27];
            a  = bus_pkg::addr_t'(r[23:20]);
            hi = lcg_next();
            queue_job(int'(p), w, a, {hi, lcg_next()});
            r = lcg_next();
            repeat (r[26:24]) @(negedge clk);
        end
        wait_idle("random traffic");

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/bus_pkg.sv
common/mem_bus_if.sv
fabric/bus_arbiter.sv
fabric/bus_port.sv
fabric/bus_fabric.sv
logic/bus_memory.sv
logic/bus_subsystem.sv
test/tb_bus_subsystem.sv

/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing -Wno-fatal -j 0
TOP       = tb_bus_subsystem
FILELIST  = tb.f
BUILD_DIR = obj_dir
PASS_TEXT = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
